// ==== ejection_pkg.sv ====
package ejection_pkg;

    localparam int NUM_PORTS  = 7;  // local, y-, y+, x+, x-, z+, z-
    localparam int FIFO_DEPTH = 4;
    localparam int TABLE_SIZE = 16;

    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // count must reach FIFO_DEPTH

    localparam int DST_W     = 8;
    localparam int WEIGHT_W  = 8;
    localparam int PAYLOAD_W = 32;

    typedef logic [2:0] port_idx_t;
    typedef logic [2:0] count_t;
    typedef logic [$clog2(TABLE_SIZE)-1:0] index_t;

    // grant value that names no port at all
    localparam port_idx_t NO_GRANT = 3'd7;

    // 54-bit flit, valid sits in the top bit
    typedef struct packed {
        logic                 valid;
        logic                 reduction;
        logic [DST_W-1:0]     dst;
        index_t               index;
        logic [WEIGHT_W-1:0]  weight;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // one reduction table entry
    typedef struct packed {
        count_t               expected;     // arrivals needed to complete
        count_t               arrived;      // arrivals seen so far
        logic [WEIGHT_W-1:0]  weight_acc;
        logic [PAYLOAD_W-1:0] payload_acc;
    } table_entry_t;

endpackage

// ==== ejection_ifs.sv ====
// head of each input FIFO and the pop strobes back from the ejection stage
interface head_if;
    import ejection_pkg::*;

    flit_t                head [NUM_PORTS];  // all zero while a FIFO is empty
    logic [NUM_PORTS-1:0] pop;

    modport fifo (output head, input pop);
    modport ejection (input head, output pop);
endinterface

// read and update ports of the reduction table
interface table_if;
    import ejection_pkg::*;

    index_t       rd_index;
    table_entry_t rd_entry;   // asynchronous read data
    logic         wr_en;
    index_t       wr_index;
    table_entry_t wr_entry;

    modport combiner (
        output rd_index, wr_en, wr_index, wr_entry,
        input  rd_entry
    );
    modport storage (
        input  rd_index, wr_en, wr_index, wr_entry,
        output rd_entry
    );
endinterface

// ==== flit_fifo.sv ====
module flit_fifo (
    input  logic                clk,
    input  logic                rst,
    input  ejection_pkg::flit_t in_flit,
    input  logic                push,
    input  logic                pop,
    output ejection_pkg::flit_t head,
    output logic                full
);
    import ejection_pkg::*;

    flit_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;
    logic                  empty;

    assign empty   = (count == '0);
    assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign do_push = push && !full;   // a flit offered while full is dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, pointers wrap
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= in_flit;
    end

    // zero head when empty keeps valid low downstream
    assign head = empty ? '0 : mem[rd_ptr];

endmodule

// ==== ejection_stage.sv ====
module ejection_stage (
    input  logic                clk,
    input  logic                rst,
    head_if.ejection            heads,
    output ejection_pkg::flit_t out_flit [ejection_pkg::NUM_PORTS],
    output ejection_pkg::flit_t red_flit
);
    import ejection_pkg::*;

    port_idx_t            grant;       // port allowed to pop its reduction head
    port_idx_t            grant_next;
    logic [NUM_PORTS-1:0] red_req;     // head is a valid reduction flit
    logic [NUM_PORTS-1:0] pop;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            red_req[i] = heads.head[i].valid && heads.head[i].reduction;
            // ordinary heads always leave, reduction heads only when granted
            pop[i] = (heads.head[i].valid && !heads.head[i].reduction) ||
                     (red_req[i] && grant == port_idx_t'(i));
        end
    end

    assign heads.pop = pop;

    // next requester after the current grant in cyclic order, never the current one
    always_comb begin
        int   start;
        int   cand;
        logic found;

        start      = (grant == NO_GRANT) ? NUM_PORTS - 1 : int'(grant);
        grant_next = NO_GRANT;
        found      = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = (start + k) % NUM_PORTS;
            if (!found && red_req[cand] && cand != int'(grant)) begin
                grant_next = port_idx_t'(cand);
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= NO_GRANT;
        end else begin
            grant <= grant_next;
        end
    end

    // pass-through registers, a reduction head shows up as an empty slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (rst || heads.head[i].reduction) begin
                out_flit[i] <= '0;
            end else begin
                out_flit[i] <= heads.head[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            red_flit <= '0;
        end else if (grant != NO_GRANT) begin
            red_flit <= heads.head[grant];   // granted head is popped in this same cycle
        end else begin
            red_flit <= '0;
        end
    end

endmodule

// ==== reduction_table.sv ====
module reduction_table (
    input  logic                 clk,
    table_if.storage             tbl,
    input  logic                 cfg_we,
    input  ejection_pkg::index_t cfg_index,
    input  ejection_pkg::count_t cfg_expect
);
    import ejection_pkg::*;

    table_entry_t entries [TABLE_SIZE];
    table_entry_t cfg_entry;

    // a fresh entry only knows how many arrivals it waits for
    always_comb begin
        cfg_entry          = '0;
        cfg_entry.expected = cfg_expect;
    end

    assign tbl.rd_entry = entries[tbl.rd_index];   // read the same cycle, no register

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            entries[cfg_index] <= cfg_entry;   // configuration wins over an update
        end else if (tbl.wr_en) begin
            entries[tbl.wr_index] <= tbl.wr_entry;
        end
    end

endmodule

// ==== reduction_combiner.sv ====
module reduction_combiner (
    input  logic                clk,
    input  logic                rst,
    input  ejection_pkg::flit_t red_flit,
    table_if.combiner           tbl,
    output ejection_pkg::flit_t out_red
);
    import ejection_pkg::*;

    flit_t                cmb_flit;     // flit in the combine stage
    table_entry_t         cmb_entry;    // entry read for it, possibly forwarded
    table_entry_t         entry_next;   // value written back this cycle
    flit_t                red_done;     // combined flit if the group completes
    count_t               arrived_new;
    logic [WEIGHT_W-1:0]  weight_sum;
    logic [PAYLOAD_W-1:0] payload_sum;
    logic                 fwd_hit;
    logic                 done;

    assign tbl.rd_index = red_flit.index;

    // the combine stage writes this index on the coming edge, so the table is stale
    assign fwd_hit = cmb_flit.valid && (cmb_flit.index == red_flit.index);

    always_ff @(posedge clk) begin
        if (rst) begin
            cmb_flit <= '0;
        end else begin
            cmb_flit <= red_flit;
        end
    end

    always_ff @(posedge clk) begin
        cmb_entry <= fwd_hit ? entry_next : tbl.rd_entry;
    end

    assign arrived_new = cmb_entry.arrived + 1'b1;
    assign weight_sum  = cmb_entry.weight_acc + cmb_flit.weight;     // wraps at 8 bits
    assign payload_sum = cmb_entry.payload_acc + cmb_flit.payload;   // wraps at 32 bits
    assign done        = cmb_flit.valid && (arrived_new == cmb_entry.expected);

    always_comb begin
        entry_next          = '0;
        entry_next.expected = cmb_entry.expected;
        if (!done) begin
            entry_next.arrived     = arrived_new;
            entry_next.weight_acc  = weight_sum;
            entry_next.payload_acc = payload_sum;
        end
        // on completion the entry goes back to zero and can take a new group

        red_done         = cmb_flit;
        red_done.weight  = weight_sum;
        red_done.payload = payload_sum;
    end

    assign tbl.wr_en    = cmb_flit.valid;
    assign tbl.wr_index = cmb_flit.index;
    assign tbl.wr_entry = entry_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_red <= '0;
        end else if (done) begin
            out_red <= red_done;
        end else begin
            out_red <= '0;   // nothing to emit, valid stays low
        end
    end

endmodule

// ==== ejection_mux.sv ====
module ejection_mux (
    input  logic                                 clk,
    input  logic                                 rst,
    input  ejection_pkg::flit_t                  in_flit  [ejection_pkg::NUM_PORTS],
    input  logic [ejection_pkg::NUM_PORTS-1:0]   in_stall,
    output logic [ejection_pkg::NUM_PORTS-1:0]   in_avail,
    output ejection_pkg::flit_t                  out_flit [ejection_pkg::NUM_PORTS],
    output ejection_pkg::flit_t                  out_red,
    input  logic                                 cfg_we,
    input  ejection_pkg::index_t                 cfg_index,
    input  ejection_pkg::count_t                 cfg_expect
);
    import ejection_pkg::*;

    head_if               heads ();
    table_if              tbl ();
    flit_t                red_flit;    // granted reduction flit, one per cycle at most
    logic [NUM_PORTS-1:0] fifo_full;

    // port order is local, y-, y+, x+, x-, z+, z-
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_fifo
        flit_fifo u_fifo (
            .clk     (clk),
            .rst     (rst),
            .in_flit (in_flit[i]),
            .push    (in_flit[i].valid && !in_stall[i]),
            .pop     (heads.pop[i]),
            .head    (heads.head[i]),
            .full    (fifo_full[i])
        );
    end

    assign in_avail = ~fifo_full;

    ejection_stage u_stage (
        .clk      (clk),
        .rst      (rst),
        .heads    (heads),
        .out_flit (out_flit),
        .red_flit (red_flit)
    );

    reduction_table u_table (
        .clk        (clk),
        .tbl        (tbl),
        .cfg_we     (cfg_we),
        .cfg_index  (cfg_index),
        .cfg_expect (cfg_expect)
    );

    reduction_combiner u_combiner (
        .clk      (clk),
        .rst      (rst),
        .red_flit (red_flit),
        .tbl      (tbl),
        .out_red  (out_red)
    );

endmodule

// ==== ejection_properties.sv ====
module ejection_properties (
    input logic                                clk,
    input logic                                rst,
    input ejection_pkg::port_idx_t             grant,
    input logic [ejection_pkg::NUM_PORTS-1:0]  red_req,
    input logic [ejection_pkg::NUM_PORTS-1:0]  pop
);
    timeunit 1ns;
    timeprecision 1ps;
    import ejection_pkg::*;

    // only the granted port may take a reduction head
    a_one_red_pop: assert property (@(posedge clk) disable iff (rst)
        $countones(pop & red_req) <= 1)
        else $error("more than one reduction pop in a cycle");

    a_grant_valid: assert property (@(posedge clk) disable iff (rst)
        (grant != NO_GRANT) |-> red_req[grant])
        else $error("grant names a port without a valid reduction head");

    // the round robin always moves on after serving a port
    a_grant_moves: assert property (@(posedge clk) disable iff (rst)
        (grant != NO_GRANT) |=> (grant != $past(grant)))
        else $error("grant stayed on the same port for two edges");

endmodule

bind ejection_stage ejection_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .red_req (red_req),
    .pop     (pop)
);

// ==== tb_ejection_mux.sv ====
module tb_ejection_mux;
    timeunit 1ns;
    timeprecision 1ps;
    import ejection_pkg::*;

    localparam int ORD_PER_PORT = 20;
    // ordinary flits, two passes over the groups of size 1 to 7, forwarding group, burst
    localparam int TOTAL_FLITS  = NUM_PORTS * ORD_PER_PORT + 2 * 28 + 6 + 6 * 7;
    localparam int MAX_CYCLES   = 200 + 8 * TOTAL_FLITS;

    logic                 clk = 1'b0;
    logic                 rst;
    flit_t                in_flit [NUM_PORTS] = '{default: '0};
    logic [NUM_PORTS-1:0] in_stall = '0;
    logic [NUM_PORTS-1:0] in_avail;
    flit_t                out_flit [NUM_PORTS];
    flit_t                out_red;
    logic                 cfg_we;
    index_t               cfg_index;
    count_t               cfg_expect;

    flit_t                tx_q [NUM_PORTS][$];        // flits still to be offered
    bit                   tx_stall_q [NUM_PORTS][$];
    flit_t                exp_q [NUM_PORTS][$];       // ordinary flits due at out_flit
    flit_t                grp_expect [TABLE_SIZE];
    int                   grp_size [TABLE_SIZE];
    int                   grp_sent [TABLE_SIZE];
    bit                   grp_open [TABLE_SIZE] = '{default: 1'b0};
    int                   groups_open = 0;
    logic [NUM_PORTS-1:0] avail_q = '0;               // in_avail as seen at the last falling edge
    logic [NUM_PORTS-1:0] offered_last = '0;
    bit                   saw_full = 1'b0;
    int                   cycles = 0;

    ejection_mux dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_flit    (in_flit),
        .in_stall   (in_stall),
        .in_avail   (in_avail),
        .out_flit   (out_flit),
        .out_red    (out_red),
        .cfg_we     (cfg_we),
        .cfg_index  (cfg_index),
        .cfg_expect (cfg_expect)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    // expected combined flit, members share dst and index so order is irrelevant
    function automatic flit_t combine_group(input flit_t members [NUM_PORTS], input int n);
        flit_t       result;
        logic [7:0]  wsum;
        logic [31:0] psum;

        result = members[0];
        wsum   = '0;
        psum   = '0;
        for (int k = 0; k < n; k++) begin
            wsum = wsum + members[k].weight;    // wraps at 8 bits
            psum = psum + members[k].payload;
        end
        result.weight  = wsum;
        result.payload = psum;
        return result;
    endfunction

    function automatic bit drained();
        bit idle;

        idle = (groups_open == 0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (tx_q[p].size() != 0 || exp_q[p].size() != 0) idle = 1'b0;
        end
        return idle;
    endfunction

    task automatic wait_drained();
        @(posedge clk);
        while (!drained()) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic configure_entry(input index_t idx, input count_t expect_cnt);
        @(posedge clk);
        cfg_we     <= 1'b1;
        cfg_index  <= idx;
        cfg_expect <= expect_cnt;
        @(posedge clk);
        cfg_we     <= 1'b0;
    endtask

    task automatic load_ordinary();
        flit_t f;
        bit    stall;

        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < ORD_PER_PORT; k++) begin
                f         = '0;
                f.valid   = 1'b1;
                f.dst     = 8'($urandom);
                f.index   = index_t'($urandom);
                f.weight  = 8'($urandom);
                f.payload = $urandom;
                stall     = ($urandom % 4) == 0;   // about one flit in four is stalled
                tx_q[p].push_back(f);
                tx_stall_q[p].push_back(stall);
            end
        end
    endtask

    // n flits for one table entry, spread round the ports first_port .. first_port+span-1
    task automatic load_group(input index_t idx, input int n, input int first_port,
                              input int span);
        flit_t      members [NUM_PORTS];
        logic [7:0] dst;
        int         port;

        dst = 8'($urandom);
        for (int k = 0; k < NUM_PORTS; k++) begin
            members[k] = '0;
        end
        for (int k = 0; k < n; k++) begin
            members[k].valid     = 1'b1;
            members[k].reduction = 1'b1;
            members[k].dst       = dst;
            members[k].index     = idx;
            members[k].weight    = 8'($urandom);
            members[k].payload   = $urandom;
            port = (first_port + k % span) % NUM_PORTS;
            tx_q[port].push_back(members[k]);
            tx_stall_q[port].push_back(1'b0);
        end
        grp_expect[idx] = combine_group(members, n);
        grp_size[idx]   = n;
        grp_sent[idx]   = 0;
        grp_open[idx]   = 1'b1;
        groups_open++;
    endtask

    task automatic check_port_flit(input int port, input flit_t got);
        flit_t want;

        if (exp_q[port].size() == 0) begin
            report_mismatch($sformatf("port %0d put out %h with nothing expected", port, got));
        end else begin
            want = exp_q[port].pop_front();
            if (got !== want) begin
                report_mismatch($sformatf("port %0d put out %h, expected %h", port, got, want));
            end
        end
    endtask

    task automatic check_red_flit(input flit_t got);
        index_t idx;

        idx = got.index;
        if (!grp_open[idx]) begin
            report_mismatch($sformatf("out_red %h has no open group", got));
        end else if (grp_sent[idx] != grp_size[idx]) begin
            report_mismatch($sformatf("out_red for index %0d before its last flit", idx));
        end else if (got !== grp_expect[idx]) begin
            report_mismatch($sformatf("out_red %h, expected %h", got, grp_expect[idx]));
        end else begin
            grp_open[idx] = 1'b0;
            groups_open--;
        end
    endtask

    // a port is offered at most every other cycle, so a flit never meets a full FIFO
    always @(posedge clk) begin
        flit_t f;
        bit    stall;

        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst && tx_q[p].size() > 0 && avail_q[p] && !offered_last[p]) begin
                f     = tx_q[p].pop_front();
                stall = tx_stall_q[p].pop_front();
                in_flit[p]      <= f;
                in_stall[p]     <= stall;
                offered_last[p] <= 1'b1;
                if (f.reduction) begin
                    grp_sent[f.index]++;
                end else if (!stall) begin
                    exp_q[p].push_back(f);
                end
            end else begin
                in_flit[p]      <= '0;
                in_stall[p]     <= 1'b0;
                offered_last[p] <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        avail_q <= in_avail;
        if (!in_avail[0]) saw_full <= 1'b1;
    end

    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_flit[p].valid !== 1'b0) check_port_flit(p, out_flit[p]);
            end
            if (out_red.valid !== 1'b0) check_red_flit(out_red);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, traffic still pending after %0d cycles", cycles);
            abort_run();
        end
    end

    initial begin
        void'($urandom(3));
        rst        = 1'b1;
        cfg_we     = 1'b0;
        cfg_index  = '0;
        cfg_expect = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (10) @(posedge clk);   // no traffic yet, every output must stay invalid

        @(negedge clk);
        load_ordinary();
        wait_drained();

        for (int g = 0; g < NUM_PORTS; g++) begin
            configure_entry(index_t'(g), count_t'(g + 1));
        end
        @(negedge clk);
        for (int g = 0; g < NUM_PORTS; g++) begin
            load_group(index_t'(g), g + 1, g, 3);
        end
        wait_drained();

        // ports 1 and 2 take turns on one index, back to back through the combine stage
        configure_entry(index_t'(8), count_t'(6));
        @(negedge clk);
        load_group(index_t'(8), 6, 1, 2);
        wait_drained();

        @(negedge clk);
        for (int g = 0; g < NUM_PORTS; g++) begin
            load_group(index_t'(g), g + 1, g + 2, 2);   // entries must restart from zero
        end
        wait_drained();

        saw_full = 1'b0;
        for (int i = 10; i < TABLE_SIZE; i++) begin
            configure_entry(index_t'(i), count_t'(7));
        end
        @(negedge clk);
        load_group(index_t'(10), 7, 0, 1);
        load_group(index_t'(11), 7, 0, 1);
        load_group(index_t'(12), 7, 0, 1);
        load_group(index_t'(13), 7, 1, 1);   // competitors slow the grant for port 0
        load_group(index_t'(14), 7, 2, 1);
        load_group(index_t'(15), 7, 3, 1);
        wait_drained();

        repeat (10) @(posedge clk);
        if (!saw_full) begin
            $display("in_avail of port 0 never went low during the reduction burst");
            abort_run();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== build.f ====
ejection_pkg.sv
ejection_ifs.sv
flit_fifo.sv
ejection_stage.sv
reduction_table.sv
reduction_combiner.sv
ejection_mux.sv
ejection_properties.sv
tb_ejection_mux.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -f build.f --top-module tb_ejection_mux -o tb_ejection_mux
	./obj_dir/tb_ejection_mux 2>&1 | tee sim.log
	grep -q "sim passed" sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log
